// File: raytrace.f
+incdir+.
raytrace_pkg.sv
ray_generator.sv
ray_box_intersect.sv
pixel_shader.sv
pixel_fifo.sv
frame_buffer_handler.sv
raytrace_core.sv
tb_raytrace_core.sv

// File: Bender.yml
package:
  name: raytrace

sources:
  - include_dirs:
      - .
    files:
      - raytrace_pkg.sv
      - ray_generator.sv
      - ray_box_intersect.sv
      - pixel_shader.sv
      - pixel_fifo.sv
      - frame_buffer_handler.sv
      - raytrace_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_raytrace_core.sv

// File: tb_raytrace_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "raytrace_defs.svh"

module tb_raytrace_core;

	import raytrace_pkg::*;

	localparam int DONE_TIMEOUT = 20000;
	localparam int IDLE_CYCLES  = 20;

	logic              clk = 1'b0;
	logic              rst_n = 1'b0;
	logic              start = 1'b0;
	logic              stripes_sel = 1'b0;
	coord_t            box_xmin = '0;
	coord_t            box_xmax = '0;
	coord_t            box_ymin = '0;
	coord_t            box_ymax = '0;
	coord_t            box_zmin = '0;
	coord_t            box_zmax = '0;
	logic              pixel_ready = 1'b0;
	logic              busy;
	logic              pixel_valid;
	logic [`PIX_W-1:0] pixel_x;
	logic [`PIX_W-1:0] pixel_y;
	rgb_t              pixel_rgb;
	logic              frame_done;

	// reference state
	logic  xfer;
	int    exp_idx;
	int    exp_x;
	int    exp_y;
	rgb_t  exp_rgb;
	int    total_xfers;
	string test_name = "reset";

	int value_errors = 0;
	int protocol_errors = 0;
	int timeout_errors = 0;
	bit timed_out = 1'b0;

	// display ready pattern
	bit ready_random = 1'b0;
	int stall_left = 0;
	int roll;

	always #50 clk = ~clk;

	raytrace_core u_raytrace_core (.clk, .rst_n, .start, .stripes_sel, .box_xmin, .box_xmax,
		.box_ymin, .box_ymax, .box_zmin, .box_zmax, .pixel_ready, .busy, .pixel_valid,
		.pixel_x, .pixel_y, .pixel_rgb, .frame_done);

	// colour of pixel (x, y) for the box and stripe mode on the inputs
	function automatic rgb_t expected_colour(input int x, input int y);
		int         ox;
		int         oy;
		int         depth;
		logic [7:0] shade;
		rgb_t       c;
		ox = x + `CAM_X;
		oy = y + `CAM_Y;
		depth = (int'(box_zmin) > 0) ? int'(box_zmin) : 0;
		shade = (depth >= 255) ? 8'd0 : 8'(255 - depth);
		if (ox >= int'(box_xmin) && ox <= int'(box_xmax) && oy >= int'(box_ymin) &&
				oy <= int'(box_ymax) && int'(box_zmax) >= 0) begin
			c = {`HIT_RED, shade, shade};
		end else if (stripes_sel && ((x >> `STRIPE_SHIFT) % 2 == 1)) begin
			c = `STRIPE_RGB;
		end else begin
			c = `BG_RGB;
		end
		return c;
	endfunction

	assign xfer = pixel_valid && pixel_ready;

	always_comb begin
		exp_x = exp_idx % `FRAME_W;
		exp_y = exp_idx / `FRAME_W;
		exp_rgb = expected_colour(exp_x, exp_y);
	end

	// raster position of the next pixel expected on the output
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_idx <= 0;
			total_xfers <= 0;
		end else if (xfer) begin
			exp_idx <= (exp_idx == `NUM_RAYS - 1) ? 0 : exp_idx + 1;
			total_xfers <= total_xfers + 1;
		end
	end

	// long low stretches now and then in random mode
	always @(negedge clk) begin
		if (!ready_random) begin
			pixel_ready = 1'b1;
		end else if (stall_left > 0) begin
			pixel_ready = 1'b0;
			stall_left--;
		end else begin
			roll = $urandom_range(0, 15);
			if (roll == 0)
				stall_left = 8 + $urandom_range(0, 24);
			pixel_ready = (roll > 5);
		end
	end

	a_coord: assert property (@(posedge clk) disable iff (!rst_n)
		xfer |-> (pixel_x == exp_x) && (pixel_y == exp_y))
		else begin
			value_errors++;
			$display("** Error: %s coordinate expected (%0d,%0d) actual (%0d,%0d)", test_name,
				$sampled(exp_x), $sampled(exp_y), $sampled(pixel_x), $sampled(pixel_y));
		end

	a_colour: assert property (@(posedge clk) disable iff (!rst_n)
		xfer |-> (pixel_rgb == exp_rgb))
		else begin
			value_errors++;
			$display("** Error: %s colour at (%0d,%0d) expected %06h actual %06h", test_name,
				$sampled(exp_x), $sampled(exp_y), $sampled(exp_rgb), $sampled(pixel_rgb));
		end

	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		pixel_valid && !pixel_ready |=> pixel_valid && $stable({pixel_x, pixel_y, pixel_rgb}))
		else begin
			protocol_errors++;
			$display("** Error: %s output pixel dropped or changed while stalled", test_name);
		end

	// one pulse, right after the last pixel of the frame
	a_done: assert property (@(posedge clk) disable iff (!rst_n)
		frame_done == $past(xfer && (exp_idx == `NUM_RAYS - 1)))
		else begin
			value_errors++;
			$display("** Error: %s frame_done expected %0b actual %0b", test_name,
				!$sampled(frame_done), $sampled(frame_done));
		end

	a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
		start && !busy |=> busy)
		else begin
			protocol_errors++;
			$display("** Error: %s busy did not rise the cycle after start", test_name);
		end

	task automatic run_frame(input string name, input int xmin, input int xmax, input int ymin,
			input int ymax, input int zmin, input int zmax, input bit stripes,
			input bit random_ready);
		int first_xfer;
		bit seen_done;
		if (timed_out)
			return;
		test_name = name;
		box_xmin = coord_t'(xmin);
		box_xmax = coord_t'(xmax);
		box_ymin = coord_t'(ymin);
		box_ymax = coord_t'(ymax);
		box_zmin = coord_t'(zmin);
		box_zmax = coord_t'(zmax);
		stripes_sel = stripes;
		ready_random = random_ready;
		first_xfer = total_xfers;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		repeat (3) @(negedge clk);
		// a second start mid-frame must be ignored
		assert (busy) else begin
			protocol_errors++;
			$display("** Error: %s busy low before the extra start pulse", name);
		end
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		seen_done = 1'b0;
		for (int i = 0; i < DONE_TIMEOUT; i++) begin
			@(negedge clk);
			if (frame_done) begin
				seen_done = 1'b1;
				break;
			end
		end
		if (!seen_done) begin
			timeout_errors++;
			timed_out = 1'b1;
			$display("** Error: %s timed out waiting for frame_done", name);
			return;
		end
		ready_random = 1'b0;
		repeat (IDLE_CYCLES) @(negedge clk);
		assert (total_xfers - first_xfer == `NUM_RAYS) else begin
			value_errors++;
			$display("** Error: %s pixel count expected %0d actual %0d", name, `NUM_RAYS,
				total_xfers - first_xfer);
		end
		assert (!busy && !pixel_valid) else begin
			protocol_errors++;
			$display("** Error: %s core still active after the frame ended", name);
		end
	endtask

	initial begin
		void'($urandom(32'hf5c2d702));
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		assert (!busy && !pixel_valid && !frame_done) else begin
			protocol_errors++;
			$display("** Error: reset outputs not idle after reset");
		end
		// middle box in front, plain background
		run_frame("frame1_plain", -3, 2, -2, 3, 40, 100, 1'b0, 1'b0);
		// camera inside the box, depth clamps to 0
		run_frame("frame2_stripes", -5, -1, -4, 0, -10, 20, 1'b1, 1'b0);
		run_frame("frame3_random_ready", 0, 6, -6, 1, 300, 400, 1'b1, 1'b1);
		// box entirely behind the camera
		run_frame("frame4_behind", -8, 7, -6, 5, -50, -5, 1'b0, 1'b0);
		$display("error counts: value %0d, protocol %0d, timeout %0d", value_errors,
			protocol_errors, timeout_errors);
		if (value_errors + protocol_errors + timeout_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule: tb_raytrace_core

`default_nettype wire

// File: raytrace_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "raytrace_defs.svh"

module raytrace_core (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  logic                 stripes_sel,
	input  raytrace_pkg::coord_t box_xmin,
	input  raytrace_pkg::coord_t box_xmax,
	input  raytrace_pkg::coord_t box_ymin,
	input  raytrace_pkg::coord_t box_ymax,
	input  raytrace_pkg::coord_t box_zmin,
	input  raytrace_pkg::coord_t box_zmax,
	input  logic                 pixel_ready,
	output logic                 busy,
	output logic                 pixel_valid,
	output logic [`PIX_W-1:0]    pixel_x,
	output logic [`PIX_W-1:0]    pixel_y,
	output raytrace_pkg::rgb_t   pixel_rgb,
	output logic                 frame_done
);

	import raytrace_pkg::*;

	logic                ray_valid;
	ray_t                ray;
	logic                hit_valid;
	hit_t                hit;
	logic                pb_we;
	pixel_buffer_entry_t pb_wdata;
	pixel_buffer_entry_t pb_rdata;
	logic                pb_re;
	logic                pb_empty;
	logic                pb_almost_full;

	ray_generator u_ray_generator (.clk, .rst_n, .start, .pb_almost_full, .busy,
		.ray_valid, .ray);

	ray_box_intersect u_ray_box_intersect (.clk, .rst_n, .ray_valid, .ray, .box_xmin,
		.box_xmax, .box_ymin, .box_ymax, .box_zmin, .box_zmax, .hit_valid, .hit);

	pixel_shader u_pixel_shader (.clk, .rst_n, .hit_valid, .hit, .stripes_sel, .pb_we,
		.pb_data(pb_wdata));

	// full is never reached, almost_full throttles the generator
	pixel_fifo #(.DEPTH(`PB_DEPTH)) u_pixel_fifo (.clk, .rst_n, .we(pb_we), .re(pb_re),
		.data_in(pb_wdata), .data_out(pb_rdata), .empty(pb_empty), .full(),
		.almost_full(pb_almost_full));

	frame_buffer_handler u_frame_buffer_handler (.clk, .rst_n, .pb_empty,
		.pb_data(pb_rdata), .pixel_ready, .pb_re, .pixel_valid, .pixel_x, .pixel_y,
		.pixel_rgb, .frame_done);

endmodule: raytrace_core

`default_nettype wire

// File: frame_buffer_handler.sv
`timescale 1ns/1ps
`default_nettype none

`include "raytrace_defs.svh"

module frame_buffer_handler (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              pb_empty,
	input  raytrace_pkg::pixel_buffer_entry_t pb_data,
	input  logic                              pixel_ready,
	output logic                              pb_re,
	output logic                              pixel_valid,
	output logic [`PIX_W-1:0]                 pixel_x,
	output logic [`PIX_W-1:0]                 pixel_y,
	output raytrace_pkg::rgb_t                pixel_rgb,
	output logic                              frame_done
);

	import raytrace_pkg::*;

	localparam int CNT_W = $clog2(`NUM_RAYS + 1);

	logic [CNT_W-1:0] xfer_cnt;
	logic             last_xfer;

	// head of the buffer goes straight to the display
	assign pixel_valid = !pb_empty;
	assign pixel_x     = pb_data.px;
	assign pixel_y     = pb_data.py;
	assign pixel_rgb   = pb_data.rgb;
	assign pb_re       = pixel_valid && pixel_ready;

	assign last_xfer = (xfer_cnt == (`NUM_RAYS - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xfer_cnt   <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= pb_re && last_xfer;
			if (pb_re) begin
				xfer_cnt <= last_xfer ? '0 : xfer_cnt + 1'b1;
			end
		end
	end

	// a stalled pixel must not change until the display takes it
	assert property (@(posedge clk) disable iff (!rst_n)
		pixel_valid && !pixel_ready |=> pixel_valid && $stable(pb_data))
		else $error("output pixel changed or dropped while stalled");

endmodule: frame_buffer_handler

`default_nettype wire

// File: pixel_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "raytrace_defs.svh"

module pixel_fifo #(
	parameter int DEPTH = `PB_DEPTH
) (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              we,
	input  logic                              re,
	input  raytrace_pkg::pixel_buffer_entry_t data_in,
	output raytrace_pkg::pixel_buffer_entry_t data_out,
	output logic                              empty,
	output logic                              full,
	output logic                              almost_full
);

	import raytrace_pkg::*;

	localparam int AW = $clog2(DEPTH);

	pixel_buffer_entry_t mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          do_wr;
	logic          do_rd;

	assign do_wr = we && !full;
	assign do_rd = re && !empty;

	assign empty       = (count == 0);
	assign full        = (count == DEPTH);
	// leaves room for the rays still in the pipe
	assign almost_full = (count >= (DEPTH - `PB_SLACK - 1));

	// head entry, valid whenever not empty
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) wr_ptr <= wr_ptr + 1'b1;
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) !(we && full))
		else $error("pixel buffer written while full, almost-full threshold too high");

	assert property (@(posedge clk) disable iff (!rst_n) !(re && empty))
		else $error("pixel buffer read while empty");

endmodule: pixel_fifo

`default_nettype wire

// File: pixel_shader.sv
`timescale 1ns/1ps
`default_nettype none

`include "raytrace_defs.svh"

module pixel_shader (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              hit_valid,
	input  raytrace_pkg::hit_t                hit,
	input  logic                              stripes_sel,
	output logic                              pb_we,
	output raytrace_pkg::pixel_buffer_entry_t pb_data
);

	import raytrace_pkg::*;

	logic [7:0] shade;
	logic       on_stripe;
	rgb_t       colour;

	// nearer surfaces are brighter, far ones fade to black
	assign shade = (hit.depth >= 255) ? 8'd0 : (8'd255 - hit.depth[7:0]);

	assign on_stripe = stripes_sel && hit.px[`STRIPE_SHIFT];

	always_comb begin
		if (hit.hit) begin
			colour.r = `HIT_RED;
			colour.g = shade;
			colour.b = shade;
		end else if (on_stripe) begin
			colour = `STRIPE_RGB;
		end else begin
			colour = `BG_RGB;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pb_we <= 1'b0;
		end else begin
			pb_we <= hit_valid;
		end
	end

	// payload register, only the strobe is reset
	always_ff @(posedge clk) begin
		if (hit_valid) begin
			pb_data.px  <= hit.px;
			pb_data.py  <= hit.py;
			pb_data.rgb <= colour;
		end
	end

endmodule: pixel_shader

`default_nettype wire

// File: ray_box_intersect.sv
`timescale 1ns/1ps
`default_nettype none

`include "raytrace_defs.svh"

module ray_box_intersect (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 ray_valid,
	input  raytrace_pkg::ray_t   ray,
	input  raytrace_pkg::coord_t box_xmin,
	input  raytrace_pkg::coord_t box_xmax,
	input  raytrace_pkg::coord_t box_ymin,
	input  raytrace_pkg::coord_t box_ymax,
	input  raytrace_pkg::coord_t box_zmin,
	input  raytrace_pkg::coord_t box_zmax,
	output logic                 hit_valid,
	output raytrace_pkg::hit_t   hit
);

	import raytrace_pkg::*;

	logic   in_x;
	logic   in_y;
	logic   ahead;
	coord_t entry_z;

	// ray is parallel to z, so only the x and y slabs matter
	assign in_x = (ray.ox >= box_xmin) && (ray.ox <= box_xmax);
	assign in_y = (ray.oy >= box_ymin) && (ray.oy <= box_ymax);

	// box must reach in front of the camera plane at z = 0
	assign ahead = (box_zmax >= 0);

	// entry depth, clamped when the origin sits inside the box
	assign entry_z = (box_zmin < 0) ? '0 : box_zmin;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hit_valid <= 1'b0;
		end else begin
			hit_valid <= ray_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (ray_valid) begin
			hit.px    <= ray.px;
			hit.py    <= ray.py;
			hit.hit   <= in_x && in_y && ahead;
			hit.depth <= entry_z;
		end
	end

endmodule: ray_box_intersect

`default_nettype wire

// File: ray_generator.sv
`timescale 1ns/1ps
`default_nettype none

`include "raytrace_defs.svh"

module ray_generator (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               start,
	input  logic               pb_almost_full,
	output logic               busy,
	output logic               ray_valid,
	output raytrace_pkg::ray_t ray
);

	import raytrace_pkg::*;

	// raster position of the next ray
	logic [`PIX_W-1:0] px;
	logic [`PIX_W-1:0] py;
	logic              last_px;
	logic              last_py;

	assign last_px = (px == (`FRAME_W - 1));
	assign last_py = (py == (`FRAME_H - 1));

	// hold off while the buffer cannot take the rays in flight
	assign ray_valid = busy && !pb_almost_full;

	always_comb begin
		ray.px = px;
		ray.py = py;
		ray.ox = coord_t'(px) + coord_t'(`CAM_X);
		ray.oy = coord_t'(py) + coord_t'(`CAM_Y);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			px   <= '0;
			py   <= '0;
		end else if (!busy) begin
			// start while busy is simply ignored
			if (start) begin
				busy <= 1'b1;
				px   <= '0;
				py   <= '0;
			end
		end else if (ray_valid) begin
			if (last_px) begin
				px <= '0;
				if (last_py) begin
					py   <= '0;
					busy <= 1'b0;
				end else begin
					py <= py + 1'b1;
				end
			end else begin
				px <= px + 1'b1;
			end
		end
	end

endmodule: ray_generator

`default_nettype wire

// File: raytrace_pkg.sv
`default_nettype none

`include "raytrace_defs.svh"

package raytrace_pkg;

	// signed scene coordinate
	typedef logic signed [`COORD_W-1:0] coord_t;

	// orthographic ray, direction is +z
	typedef struct packed {
		logic [`PIX_W-1:0] px;
		logic [`PIX_W-1:0] py;
		coord_t            ox;
		coord_t            oy;
	} ray_t;

	typedef struct packed {
		logic [`PIX_W-1:0] px;
		logic [`PIX_W-1:0] py;
		logic              hit;
		coord_t            depth;
	} hit_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// fifo payload and display output
	typedef struct packed {
		logic [`PIX_W-1:0] px;
		logic [`PIX_W-1:0] py;
		rgb_t              rgb;
	} pixel_buffer_entry_t;

endpackage: raytrace_pkg

`default_nettype wire

// File: raytrace_defs.svh
`ifndef RAYTRACE_DEFS_SVH
`define RAYTRACE_DEFS_SVH

// frame size in pixels
`define FRAME_W 16
`define FRAME_H 12
`define NUM_RAYS (`FRAME_W * `FRAME_H)

// pixel coordinate and scene coordinate widths
`define PIX_W 5
`define COORD_W 12

// camera plane offset, centres the frame on the z axis
`define CAM_X (-8)
`define CAM_Y (-6)

// colours
`define HIT_RED 8'd255
`define BG_RGB 24'h102040
`define STRIPE_RGB 24'hc0c0c0

// pixel x bit that picks a stripe
`define STRIPE_SHIFT 2

// pixel buffer sizing
`define PB_DEPTH 8
`define PB_SLACK 2

`endif
